// ==== common/tea_consts.svh ====
// TEA cipher constants
// delta step, starting sum for decryption,
// and low bit positions of the four key words

`ifndef TEA_CONSTS_SVH
`define TEA_CONSTS_SVH

// per-round sum step, golden ratio derived
`define TEA_DELTA     32'h9e3779b9

// delta * 32 truncated to 32 bits, sum of the first decrypt round
`define TEA_SUM_INIT  32'hc6ef3720

// key word slicing, each word is 32 bits wide
`define TEA_K0_LSB    0
`define TEA_K1_LSB    32
`define TEA_K2_LSB    64
`define TEA_K3_LSB    96

`endif

// ==== common/tea_pkg.sv ====
// shared types for the TEA block decryptor
// word, block and key vectors plus the control FSM states
// block layout: V1 in bits 63..32, V0 in bits 31..0
// key layout: k0 in bits 31..0 up to k3 in bits 127..96

package tea_pkg;

	// one cipher word, also used for the running sum
	typedef logic [31:0] tea_word_t;

	// a full 64-bit block, {v1, v0}
	typedef logic [63:0] tea_block_t;

	// 128-bit key, four words packed low to high
	typedef logic [127:0] tea_key_t;

	// control FSM states
	// st_idle  waiting for req, load on accept
	// st_run   one half-round per clock
	// st_done  ack held until req drops
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2
	} dec_state_t;

endpackage : tea_pkg

// ==== sim.f ====
+incdir+common
common/tea_pkg.sv
tea_dec/tea_round_counter.sv
tea_dec/tea_ctrl_fsm.sv
tea_dec/tea_datapath.sv
tea_dec/tea_dec_top.sv
test/tea_dec_sva.sv
test/tb_tea_dec.sv

// ==== tea_dec/tea_ctrl_fsm.sv ====
// control FSM for the TEA decryptor
// st_idle -> st_run on req, st_run -> st_done on last,
// st_done -> st_idle once req is low
// drives load and step to the counter and datapath,
// and the registered ack toward the requester

`timescale 1ns/1ps

module tea_ctrl_fsm import tea_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req,   // requester strobe
	input  logic last,  // final half-round from the counter
	output logic load,  // capture block and key
	output logic step,  // advance one half-round
	output logic ack    // result valid
);

	dec_state_t state;
	dec_state_t state_nxt;

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				// new request only accepted here
				if (req) begin
					state_nxt = st_run;
				end
			end
			st_run: begin
				// counter decides when the run ends
				if (last) begin
					state_nxt = st_done;
				end
			end
			st_done: begin
				// wait for the requester to drop req
				if (!req) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;  // recover from unused code
			end
		endcase
	end

	// state register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// load is one cycle wide, the accept edge leaves st_idle
	assign load = (state == st_idle) && req;

	// one half-round per clock for the whole run
	assign step = (state == st_run);

	// ack follows the next state so it rises right after the
	// edge that sees last, and falls right after req is seen low
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= (state_nxt == st_done);
		end
	end

endmodule : tea_ctrl_fsm

// ==== tea_dec/tea_datapath.sv ====
// datapath for the TEA decryptor
// v0/v1 word registers and the latched key
// one shared half-round mix, applied to v1 or v0 by phase
// out_block is the register pair {v1, v0}

`timescale 1ns/1ps

module tea_datapath import tea_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       load,       // capture block and key
	input  logic       step,       // apply one half-round
	input  logic       half,       // 0 updates v1, 1 updates v0
	input  tea_word_t  sum,        // sum of the current round
	input  tea_block_t in_block,   // ciphertext {v1, v0}
	input  tea_key_t   key,        // 128-bit key
	output tea_block_t out_block   // current words {v1, v0}
);

	`include "tea_consts.svh"

	tea_word_t v0;     // low word
	tea_word_t v1;     // high word
	tea_key_t  key_q;  // key held for the whole run

	// key words, sliced from the latched copy
	tea_word_t k0;
	tea_word_t k1;
	tea_word_t k2;
	tea_word_t k3;

	// half-round operands, picked by phase
	tea_word_t mix_src;  // word feeding the mix
	tea_word_t mix_ka;   // added to the left-shifted term
	tea_word_t mix_kb;   // added to the right-shifted term
	tea_word_t mix_val;  // value subtracted from the other word

	// TEA mix, ((w << 4) + ka) ^ (w + s) ^ ((w >> 5) + kb)
	function automatic tea_word_t tea_mix(
		input tea_word_t w,
		input tea_word_t s,
		input tea_word_t ka,
		input tea_word_t kb
	);
		tea_word_t t_shl;
		tea_word_t t_sum;
		tea_word_t t_shr;
		t_shl = (w << 4) + ka;
		t_sum = w + s;
		t_shr = (w >> 5) + kb;  // logical shift, unsigned word
		return t_shl ^ t_sum ^ t_shr;
	endfunction

	assign k0 = key_q[`TEA_K0_LSB +: 32];
	assign k1 = key_q[`TEA_K1_LSB +: 32];
	assign k2 = key_q[`TEA_K2_LSB +: 32];
	assign k3 = key_q[`TEA_K3_LSB +: 32];

	// first half mixes v0 with k2/k3, second mixes v1 with k0/k1
	assign mix_src = half ? v1 : v0;
	assign mix_ka  = half ? k0 : k2;
	assign mix_kb  = half ? k1 : k3;
	assign mix_val = tea_mix(mix_src, sum, mix_ka, mix_kb);

	// word and key registers
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v0    <= '0;
			v1    <= '0;
			key_q <= '0;
		end else if (load) begin
			v0    <= in_block[31:0];
			v1    <= in_block[63:32];
			key_q <= key;  // inputs may change after this edge
		end else if (step) begin
			if (half) begin
				v0 <= v0 - mix_val;  // uses v1 from the first half
			end else begin
				v1 <= v1 - mix_val;
			end
		end
	end

	assign out_block = {v1, v0};

endmodule : tea_datapath

// ==== tea_dec/tea_dec_top.sv ====
// TEA block decryptor, top level
// one block in flight, 64 clocks per block (one half-round each)
// four-phase req/ack handshake toward the requester
// holds the control FSM, the round counter and the datapath

`timescale 1ns/1ps

module tea_dec_top import tea_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       req,       // request, held until ack seen
	input  tea_block_t in_block,  // ciphertext, sampled with first req
	input  tea_key_t   key,       // key, sampled with first req
	output logic       ack,       // plaintext ready
	output tea_block_t out_block  // plaintext, stable while ack high
);

	// control strobes from the FSM
	logic      load;  // capture inputs, restart counter
	logic      step;  // apply one half-round

	// round counter state toward the datapath
	logic      half;  // 0 updates v1, 1 updates v0
	tea_word_t sum;   // running sum for the current round
	logic      last;  // final half-round in progress

	// handshake and sequencing
	tea_ctrl_fsm u_fsm (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.last (last),
		.load (load),
		.step (step),
		.ack  (ack)
	);

	// phase bit and sum, counts 64 steps from a load
	tea_round_counter u_cnt (
		.clk  (clk),
		.rst  (rst),
		.load (load),
		.step (step),
		.half (half),
		.sum  (sum),
		.last (last)
	);

	// v0/v1 words, key register and the shared half-round logic
	tea_datapath u_dp (
		.clk       (clk),
		.rst       (rst),
		.load      (load),
		.step      (step),
		.half      (half),
		.sum       (sum),
		.in_block  (in_block),
		.key       (key),
		.out_block (out_block)
	);

	// timing summary, edge 0 samples req in st_idle
	//   edge 0       load, state -> st_run
	//   edges 1..64  step, one half-round each
	//   edge 64      last seen, state -> st_done, ack rises
	//   req low      ack falls on that same edge, back to st_idle
	// out_block only moves on load or step, neither
	// happens in st_done, so the result holds under ack

endmodule : tea_dec_top

// ==== tea_dec/tea_round_counter.sv ====
// round counter for the TEA decryptor
// half-round phase bit and running sum
// sum starts at delta*32 and drops by delta after each full round
// last marks the second half of the round whose sum is delta,
// 64 steps after a load

`timescale 1ns/1ps

module tea_round_counter import tea_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      load,  // restart for a new block
	input  logic      step,  // one half-round done this edge
	output logic      half,  // current phase, 0 first half
	output tea_word_t sum,   // sum for the current round
	output logic      last   // final half-round in progress
);

	`include "tea_consts.svh"

	// phase toggles every step, sum moves once per full round
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			half <= 1'b0;
			sum  <= '0;
		end else if (load) begin
			half <= 1'b0;
			sum  <= `TEA_SUM_INIT;  // delta * 32
		end else if (step) begin
			half <= ~half;
			if (half) begin
				sum <= sum - `TEA_DELTA;  // round complete
			end
		end
	end

	// sum only reaches delta in round 32
	// no wrap issue, the run stops there
	assign last = half && (sum == `TEA_DELTA);

endmodule : tea_round_counter

// ==== test/tb_tea_dec.sv ====
// testbench for the TEA block decryptor
// LFSR stimulus, TEA encrypt and decrypt models,
// four-phase req/ack driver, latency and hold checks,
// error counts in one closing line

`timescale 1ns/1ps

module tb_tea_dec import tea_pkg::*; ();

	`include "tea_consts.svh"

	logic       clk;
	logic       rst;
	logic       req;
	tea_block_t in_block;
	tea_key_t   key;
	logic       ack;
	tea_block_t out_block;

	logic [31:0] lfsr = 32'h9b18;  // galois LFSR state
	int value_errs = 0;
	int timeout_errs = 0;
	bit aborted = 0;  // stop issuing blocks after a hang

	tea_dec_top u_dut (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.in_block  (in_block),
		.key       (key),
		.ack       (ack),
		.out_block (out_block)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// one LFSR step per bit, lsb shifted out is the bit taken
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		logic         b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) begin
				lfsr = lfsr ^ 32'h80200003;  // x^32+x^22+x^2+x+1
			end
			v = {v[126:0], b};
		end
		return v;
	endfunction

	// ((w << 4) + ka) ^ (w + s) ^ ((w >> 5) + kb)
	function automatic tea_word_t feistel_mix(input tea_word_t w, input tea_word_t s,
						  input tea_word_t ka, input tea_word_t kb);
		return ((w << 4) + ka) ^ (w + s) ^ ((w >> 5) + kb);
	endfunction

	// reference encrypt, sum runs up from delta
	function automatic tea_block_t encrypt_block(input tea_block_t pt, input tea_key_t k);
		tea_word_t v0;
		tea_word_t v1;
		tea_word_t s;
		v0 = pt[31:0];
		v1 = pt[63:32];
		s  = '0;
		for (int r = 0; r < 32; r++) begin
			s  = s + `TEA_DELTA;
			v0 = v0 + feistel_mix(v1, s, k[`TEA_K0_LSB +: 32], k[`TEA_K1_LSB +: 32]);
			v1 = v1 + feistel_mix(v0, s, k[`TEA_K2_LSB +: 32], k[`TEA_K3_LSB +: 32]);
		end
		return {v1, v0};
	endfunction

	// reference decrypt, sum runs down from delta * 32
	function automatic tea_block_t decrypt_block(input tea_block_t ct, input tea_key_t k);
		tea_word_t v0;
		tea_word_t v1;
		tea_word_t s;
		v0 = ct[31:0];
		v1 = ct[63:32];
		s  = `TEA_SUM_INIT;
		for (int r = 0; r < 32; r++) begin
			v1 = v1 - feistel_mix(v0, s, k[`TEA_K2_LSB +: 32], k[`TEA_K3_LSB +: 32]);
			v0 = v0 - feistel_mix(v1, s, k[`TEA_K0_LSB +: 32], k[`TEA_K1_LSB +: 32]);
			s  = s - `TEA_DELTA;
		end
		return {v1, v0};
	endfunction

	task automatic check_block(input string name, input tea_block_t exp, input tea_block_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, act);
			value_errs++;
		end
	endtask

	// one full handshake, inputs driven on the falling edge
	task automatic run_block(input tea_block_t ct, input tea_key_t k, input tea_block_t pt,
				 input int hold, input bit scramble);
		tea_block_t model_pt;
		tea_block_t held;
		int         n;
		model_pt = decrypt_block(ct, k);
		@(negedge clk);
		in_block = ct;
		key      = k;
		req      = 1'b1;  // next rising edge is edge 0
		n = 0;
		while (!ack && n < 200) begin
			@(negedge clk);
			n++;
			if (n == 1 && scramble) begin  // edge 0 already sampled
				in_block = tea_block_t'(rand_bits(64));
				key      = rand_bits(128);
			end
		end
		if (!ack) begin
			$display("timeout at %0t ns, ack never rose after the request", $time);
			timeout_errs++;
			aborted = 1;
			req = 1'b0;
			return;
		end
		check_count("ack latency", 64, n - 1);  // edges after edge 0
		check_block("out_block", pt, out_block);
		check_block("out_block (decrypt model)", model_pt, out_block);
		held = out_block;
		repeat (hold) begin  // requester keeps req high
			@(negedge clk);
			check_count("ack", 1, int'(ack));
			check_block("out_block (held)", held, out_block);
		end
		req = 1'b0;
		n = 0;
		while (ack && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (ack) begin
			$display("timeout at %0t ns, ack stayed high after req dropped", $time);
			timeout_errs++;
			aborted = 1;
			return;
		end
		check_count("ack fall delay", 1, n);  // one edge after req seen low
	endtask

	initial begin
		tea_key_t   k;
		tea_block_t pt;
		int         hold;
		rst      = 1'b1;
		req      = 1'b0;
		in_block = '0;
		key      = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_count("ack", 0, int'(ack));  // idle after reset
		check_block("out_block", '0, out_block);
		// all-zero key and plaintext
		run_block(encrypt_block('0, '0), '0, '0, 0, 1'b0);
		for (int t = 0; t < 40 && !aborted; t++) begin
			k    = rand_bits(128);
			pt   = tea_block_t'(rand_bits(64));
			hold = int'(rand_bits(4));  // 0..15 extra cycles
			run_block(encrypt_block(pt, k), k, pt, hold, 1'b1);
		end
		$display("value errors %0d, timeout errors %0d, assertion errors %0d",
			 value_errs, timeout_errs, u_dut.u_sva.assert_errs);
		if (value_errs == 0 && timeout_errs == 0 && u_dut.u_sva.assert_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : tb_tea_dec

// ==== test/tea_dec_sva.sv ====
// handshake and stability assertions for the TEA decryptor
// bound into tea_dec_top, sees the FSM state through the bind

`timescale 1ns/1ps

module tea_dec_sva import tea_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       req,
	input logic       ack,
	input tea_block_t out_block,
	input dec_state_t state  // from u_fsm
);

	int assert_errs = 0;  // failed assertion count

	// no ack during reset
	ack_low_in_reset: assert property (@(posedge clk) rst |-> !ack)
		else begin
			$error("ack high during reset");
			assert_errs++;
		end

	// result frozen while ack held
	out_stable_under_ack: assert property (@(posedge clk) disable iff (rst)
		(ack && $past(ack)) |-> $stable(out_block))
		else begin
			$error("out_block moved while ack high");
			assert_errs++;
		end

	// ack drops only once req was seen low
	ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> !$past(req))
		else begin
			$error("ack fell with req still high");
			assert_errs++;
		end

	// ack rises only at the end of a run
	ack_rise_from_run: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> ($past(state) == st_run))
		else begin
			$error("ack rose outside st_run");
			assert_errs++;
		end

endmodule : tea_dec_sva

bind tea_dec_top tea_dec_sva u_sva (
	.clk       (clk),
	.rst       (rst),
	.req       (req),
	.ack       (ack),
	.out_block (out_block),
	.state     (u_fsm.state)
);
